/* adc_packet.f */
hdl/adc_packet_pkg.sv
hdl/conversion_sequencer.sv
hdl/channel_capture.sv
hdl/packet_assembler.sv
hdl/adc_packet_top.sv
verification/adc_packet_tb.sv
verification/adc_packet_assertions.sv

/* hdl/adc_packet_pkg.sv */
package adc_packet_pkg;

    // Field widths of the 32-bit output word
    localparam int SAMPLE_WIDTH        = 16;
    localparam int ROW_FIELD_WIDTH     = 6;
    localparam int CHANNEL_FIELD_WIDTH = 8;
    localparam int FRAME_COUNT_WIDTH   = 16;

    // Word-type codes in the top two bits, 00 is never sent
    localparam logic [1:0] WORD_TYPE_HEADER = 2'b01;
    localparam logic [1:0] WORD_TYPE_SAMPLE = 2'b10;
    localparam logic [1:0] WORD_TYPE_FOOTER = 2'b11;

    // Header and footer layout
    typedef struct packed {
        logic [1:0]                   word_type;
        logic [13:0]                  reserved;
        logic [FRAME_COUNT_WIDTH-1:0] frame_count;
    } marker_word_t;

    // Sample layout
    typedef struct packed {
        logic [1:0]                     word_type;
        logic [ROW_FIELD_WIDTH-1:0]     row;
        logic [CHANNEL_FIELD_WIDTH-1:0] channel;
        logic [SAMPLE_WIDTH-1:0]        sample;
    } sample_word_t;

    // The word_type field lines up in both views and tells which one applies
    typedef union packed {
        marker_word_t marker;
        sample_word_t sample;
    } packet_word_u;

endpackage

/* hdl/adc_packet_top.sv */
`timescale 1ns/1ps

module adc_packet_top #(
    parameter int NUM_CHANNELS = 16,
    parameter int ROWS         = 4
) (
    input  logic                                    CLK,
    input  logic                                    reset,
    input  logic                                    sample_valid,
    input  logic [adc_packet_pkg::SAMPLE_WIDTH-1:0] sample_data [NUM_CHANNELS],
    output adc_packet_pkg::packet_word_u            data_out,
    output logic                                    wr_en
);

    import adc_packet_pkg::*;

    localparam int ADDR_W = $clog2(ROWS) + 1;

    logic                         write_en;
    logic [ADDR_W-1:0]            write_addr;
    logic                         frame_ready;
    logic                         ready_bank;
    logic [FRAME_COUNT_WIDTH-1:0] frame_count;
    logic [ADDR_W-1:0]            read_addr;
    logic [SAMPLE_WIDTH-1:0]      read_data [NUM_CHANNELS];

    conversion_sequencer #(
        .ROWS (ROWS)
    ) u_sequencer (
        .CLK          (CLK),
        .reset        (reset),
        .sample_valid (sample_valid),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .frame_ready  (frame_ready),
        .ready_bank   (ready_bank),
        .frame_count  (frame_count)
    );

    // One buffer per ADC channel, all sharing the write and read addresses
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
    begin : g_channel
        channel_capture #(
            .ROWS (ROWS)
        ) u_capture (
            .CLK          (CLK),
            .reset        (reset),
            .sample_valid (sample_valid),
            .sample_in    (sample_data[ch]),
            .write_en     (write_en),
            .write_addr   (write_addr),
            .read_addr    (read_addr),
            .read_data    (read_data[ch])
        );
    end

    packet_assembler #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .ROWS         (ROWS)
    ) u_assembler (
        .CLK          (CLK),
        .reset        (reset),
        .frame_ready  (frame_ready),
        .ready_bank   (ready_bank),
        .frame_count  (frame_count),
        .read_data    (read_data),
        .read_addr    (read_addr),
        .data_out     (data_out),
        .wr_en        (wr_en)
    );

endmodule

/* hdl/channel_capture.sv */
`timescale 1ns/1ps

module channel_capture #(
    parameter int ROWS = 4
) (
    input  logic                                    CLK,
    input  logic                                    reset,
    input  logic                                    sample_valid,
    input  logic [adc_packet_pkg::SAMPLE_WIDTH-1:0] sample_in,
    input  logic                                    write_en,
    input  logic [$clog2(ROWS):0]                   write_addr,
    input  logic [$clog2(ROWS):0]                   read_addr,
    output logic [adc_packet_pkg::SAMPLE_WIDTH-1:0] read_data
);

    import adc_packet_pkg::*;

    localparam int ROW_W = $clog2(ROWS);
    localparam int IDX_W = ROW_W + 1;

    logic [SAMPLE_WIDTH-1:0] sample_reg;
    logic [SAMPLE_WIDTH-1:0] buffer [2*ROWS];

    // Bank 1 sits directly above bank 0, so ROWS need not be a power of two
    function automatic logic [IDX_W-1:0] buffer_index(input logic [IDX_W-1:0] addr);
        logic [IDX_W-1:0] row_part;
        row_part = {1'b0, addr[ROW_W-1:0]};
        return addr[ROW_W] ? row_part + IDX_W'(ROWS) : row_part;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (sample_valid)
        begin
            sample_reg <= sample_in;
        end
        if (write_en)
        begin
            buffer[buffer_index(write_addr)] <= sample_reg;
        end
    end

    // One-cycle read port, free to drain one bank while the other fills
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            read_data <= '0;
        end
        else
        begin
            read_data <= buffer[buffer_index(read_addr)];
        end
    end

endmodule

/* hdl/conversion_sequencer.sv */
`timescale 1ns/1ps

module conversion_sequencer #(
    parameter int ROWS = 4
) (
    input  logic                                         CLK,
    input  logic                                         reset,
    input  logic                                         sample_valid,
    output logic                                         write_en,
    output logic [$clog2(ROWS):0]                        write_addr,
    output logic                                         frame_ready,
    output logic                                         ready_bank,
    output logic [adc_packet_pkg::FRAME_COUNT_WIDTH-1:0] frame_count
);

    localparam int ROW_W = $clog2(ROWS);

    logic [ROW_W-1:0] row;
    logic             bank;
    logic             last_row;

    assign last_row = (row == ROW_W'(ROWS - 1));

    // Row and bank pointers, plus the strobes that follow each conversion
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            row         <= '0;
            bank        <= 1'b0;
            write_en    <= 1'b0;
            frame_ready <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            write_en    <= sample_valid;
            frame_ready <= sample_valid && last_row;

            // The number is held through the pulse and moves on right after it
            if (frame_ready)
            begin
                frame_count <= frame_count + 1'b1;
            end

            if (sample_valid)
            begin
                if (last_row)
                begin
                    row  <= '0;
                    bank <= ~bank;
                end
                else
                begin
                    row <= row + 1'b1;
                end
            end
        end
    end

    // Address of the conversion being written, and the bank that just filled
    always_ff @(posedge CLK)
    begin
        if (sample_valid)
        begin
            write_addr <= {bank, row};
            if (last_row)
            begin
                ready_bank <= bank;
            end
        end
    end

endmodule

/* hdl/packet_assembler.sv */
`timescale 1ns/1ps

module packet_assembler #(
    parameter int NUM_CHANNELS = 16,
    parameter int ROWS         = 4
) (
    input  logic                                         CLK,
    input  logic                                         reset,
    input  logic                                         frame_ready,
    input  logic                                         ready_bank,
    input  logic [adc_packet_pkg::FRAME_COUNT_WIDTH-1:0] frame_count,
    input  logic [adc_packet_pkg::SAMPLE_WIDTH-1:0]      read_data [NUM_CHANNELS],
    output logic [$clog2(ROWS):0]                        read_addr,
    output adc_packet_pkg::packet_word_u                 data_out,
    output logic                                         wr_en
);

    import adc_packet_pkg::*;

    localparam int ROW_W = $clog2(ROWS);
    localparam int CH_W  = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SAMPLE = 2'd1;
    localparam logic [1:0] ST_FOOTER = 2'd2;

    logic [1:0]                   state;
    logic                         bank_q;
    logic [FRAME_COUNT_WIDTH-1:0] frame_q;

    // Address stage counters and their one-cycle-delayed copies
    logic [ROW_W-1:0] row_a;
    logic [CH_W-1:0]  chan_a;
    logic [ROW_W-1:0] row_d;
    logic [CH_W-1:0]  chan_d;

    logic last_chan_a;
    logic last_row_a;
    logic last_d;
    logic advance;

    assign last_chan_a = (chan_a == CH_W'(NUM_CHANNELS - 1));
    assign last_row_a  = (row_a == ROW_W'(ROWS - 1));
    assign last_d      = (row_d == ROW_W'(ROWS - 1)) && (chan_d == CH_W'(NUM_CHANNELS - 1));

    // The first address goes out in the frame_ready cycle itself, so the
    // first sample is ready right behind the header
    assign advance = ((state == ST_IDLE) && frame_ready)
                  || ((state == ST_SAMPLE) && !last_d);

    // Whole rows are read at once, the channel index only picks the lane
    assign read_addr = {(state == ST_IDLE) ? ready_bank : bank_q, row_a};

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            row_a  <= '0;
            chan_a <= '0;
        end
        else if (advance)
        begin
            if (last_chan_a)
            begin
                chan_a <= '0;
                row_a  <= last_row_a ? '0 : row_a + 1'b1;
            end
            else
            begin
                chan_a <= chan_a + 1'b1;
            end
        end
    end

    // Matches the one-cycle read latency of the channel buffers
    always_ff @(posedge CLK)
    begin
        row_d  <= row_a;
        chan_d <= chan_a;
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            wr_en <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    wr_en <= frame_ready;
                    if (frame_ready)
                    begin
                        state <= ST_SAMPLE;
                    end
                end
                ST_SAMPLE:
                begin
                    wr_en <= 1'b1;
                    if (last_d)
                    begin
                        state <= ST_FOOTER;
                    end
                end
                ST_FOOTER:
                begin
                    wr_en <= 1'b1;
                    state <= ST_IDLE;
                end
                default:
                begin
                    wr_en <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Output word, packed through whichever view its type calls for
    always_ff @(posedge CLK)
    begin
        case (state)
            ST_IDLE:
            begin
                if (frame_ready)
                begin
                    bank_q          <= ready_bank;
                    frame_q         <= frame_count;
                    data_out.marker <= '{word_type:   WORD_TYPE_HEADER,
                                         reserved:    '0,
                                         frame_count: frame_count};
                end
            end
            ST_SAMPLE:
            begin
                data_out.sample <= '{word_type: WORD_TYPE_SAMPLE,
                                     row:       ROW_FIELD_WIDTH'(row_d),
                                     channel:   CHANNEL_FIELD_WIDTH'(chan_d),
                                     sample:    read_data[chan_d]};
            end
            ST_FOOTER:
            begin
                data_out.marker <= '{word_type:   WORD_TYPE_FOOTER,
                                     reserved:    '0,
                                     frame_count: frame_q};
            end
            default:
            begin
                data_out <= data_out;
            end
        endcase
    end

endmodule

/* verification/adc_packet_assertions.sv */
`timescale 1ns/1ps

module adc_packet_assertions #(
    parameter int NUM_CHANNELS = 16,
    parameter int ROWS         = 4
) (
    input logic                         CLK,
    input logic                         reset,
    input logic                         sample_valid,
    input logic                         wr_en,
    input adc_packet_pkg::packet_word_u data_out
);

    import adc_packet_pkg::*;

    localparam int PKT_LEN = ROWS * NUM_CHANNELS + 2;

    logic is_header;
    logic is_footer;

    assign is_header = wr_en && (data_out.marker.word_type == WORD_TYPE_HEADER);
    assign is_footer = wr_en && (data_out.marker.word_type == WORD_TYPE_FOOTER);

    no_empty_type: assert property (@(posedge CLK) disable iff (reset)
        wr_en |-> data_out.marker.word_type != 2'b00)
        else $error("Word with type 00 was sent");

    header_then_sample: assert property (@(posedge CLK) disable iff (reset)
        is_header |=> wr_en && (data_out.sample.word_type == WORD_TYPE_SAMPLE))
        else $error("Header was not followed by a sample word");

    // Samples keep wr_en high until the footer closes the packet
    packet_length: assert property (@(posedge CLK) disable iff (reset)
        is_header |=> (wr_en && !is_footer) [*PKT_LEN-2] ##1 is_footer)
        else $error("Packet length differs from %0d words", PKT_LEN);

    strobe_spacing: assert property (@(posedge CLK) disable iff (reset)
        sample_valid |=> !sample_valid [*NUM_CHANNELS])
        else $error("Conversion strobes arrived closer than %0d cycles", NUM_CHANNELS + 1);

endmodule

bind adc_packet_top adc_packet_assertions #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .ROWS         (ROWS)
) u_assertions (
    .CLK          (CLK),
    .reset        (reset),
    .sample_valid (sample_valid),
    .wr_en        (wr_en),
    .data_out     (data_out)
);

/* verification/adc_packet_tb.sv */
`timescale 1ns/1ps

module adc_packet_tb;

    import adc_packet_pkg::*;

    localparam int NUM_CHANNELS   = 16;
    localparam int ROWS           = 4;
    localparam int NUM_FRAMES     = 6;
    localparam int WIDE_SPACING   = NUM_CHANNELS + 9;
    localparam int PKT_LEN        = ROWS * NUM_CHANNELS + 2;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * ROWS * WIDE_SPACING + 200;

    logic                    CLK;
    logic                    reset;
    logic                    sample_valid;
    logic [SAMPLE_WIDTH-1:0] sample_data [NUM_CHANNELS];
    packet_word_u            data_out;
    logic                    wr_en;

    // Every sample that was strobed in, conversion after conversion
    logic [SAMPLE_WIDTH-1:0] sample_q [$];
    logic [31:0]             rng_state = 32'd47877;
    int                      frame_num = 0;
    int                      word_pos  = 0;

    adc_packet_top #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .ROWS         (ROWS)
    ) dut (
        .CLK          (CLK),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .data_out     (data_out),
        .wr_en        (wr_en)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Header, then samples in row-major order, then footer
    function automatic packet_word_u expected_word(input int frame, input int pos,
                                                   input logic [SAMPLE_WIDTH-1:0] samples [$]);
        packet_word_u w;
        int           idx;
        int           row;
        int           chan;
        w    = '0;
        idx  = pos - 1;
        row  = idx / NUM_CHANNELS;
        chan = idx % NUM_CHANNELS;
        if (pos == 0 || pos == PKT_LEN - 1)
        begin
            w.marker.word_type   = (pos == 0) ? WORD_TYPE_HEADER : WORD_TYPE_FOOTER;
            w.marker.frame_count = FRAME_COUNT_WIDTH'(frame);
        end
        else
        begin
            w.sample.word_type = WORD_TYPE_SAMPLE;
            w.sample.row       = ROW_FIELD_WIDTH'(row);
            w.sample.channel   = CHANNEL_FIELD_WIDTH'(chan);
            w.sample.sample    = samples[(frame * ROWS + row) * NUM_CHANNELS + chan];
        end
        return w;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error: data_out.%s got 0x%0h expected 0x%0h", field, got, exp);
        fail_run("Output word does not match the expected word");
    endtask

    task automatic check_marker(input packet_word_u got, input packet_word_u exp);
        if (got.marker.word_type !== exp.marker.word_type)
            report_mismatch("marker.word_type", got.marker.word_type, exp.marker.word_type);
        if (got.marker.reserved !== exp.marker.reserved)
            report_mismatch("marker.reserved", got.marker.reserved, exp.marker.reserved);
        if (got.marker.frame_count !== exp.marker.frame_count)
            report_mismatch("marker.frame_count", got.marker.frame_count,
                            exp.marker.frame_count);
    endtask

    task automatic check_sample(input packet_word_u got, input packet_word_u exp);
        if (got.sample.word_type !== exp.sample.word_type)
            report_mismatch("sample.word_type", got.sample.word_type, exp.sample.word_type);
        if (got.sample.row !== exp.sample.row)
            report_mismatch("sample.row", got.sample.row, exp.sample.row);
        if (got.sample.channel !== exp.sample.channel)
            report_mismatch("sample.channel", got.sample.channel, exp.sample.channel);
        if (got.sample.sample !== exp.sample.sample)
            report_mismatch("sample.sample", got.sample.sample, exp.sample.sample);
    endtask

    // Called 1 ns after an edge, returns 1 ns after the edge that allows the next strobe
    task automatic send_conversion(input int spacing);
        sample_valid = 1'b1;
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
        begin
            rng_state       = xorshift32(rng_state);
            sample_data[ch] = rng_state[SAMPLE_WIDTH-1:0];
            sample_q.push_back(sample_data[ch]);
        end
        @(posedge CLK);
        #1 sample_valid = 1'b0;
        repeat (spacing - 1) @(posedge CLK);
        #1;
    endtask

    initial
    begin
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '{default: '0};
        repeat (4) @(posedge CLK);
        #1 reset = 1'b0;
        // The first two frames are slow, the rest run at the minimum spacing
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                send_conversion((f < 2) ? WIDE_SPACING : NUM_CHANNELS + 1);
            end
        end
        wait (frame_num == NUM_FRAMES);
        repeat (ROWS * (NUM_CHANNELS + 1)) @(posedge CLK);
        $display("RESULT: PASS");
        $finish;
    end

    // Outputs settle after the rising edge, so they are read on the falling one
    always @(negedge CLK)
    begin
        packet_word_u exp_word;
        if (!reset && wr_en)
        begin
            if (word_pos == 0 && sample_q.size() < (frame_num + 1) * ROWS * NUM_CHANNELS)
                fail_run("A packet started before all rows of its frame were strobed in");
            exp_word = expected_word(frame_num, word_pos, sample_q);
            if (word_pos == 0 || word_pos == PKT_LEN - 1)
                check_marker(data_out, exp_word);
            else
                check_sample(data_out, exp_word);
            if (word_pos == PKT_LEN - 1)
            begin
                word_pos  = 0;
                frame_num = frame_num + 1;
            end
            else
            begin
                word_pos = word_pos + 1;
            end
        end
        else if (!reset && word_pos != 0)
        begin
            fail_run("wr_en dropped before the footer of a packet");
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        fail_run("Watchdog expired because packets stopped arriving");
    end

endmodule
